// ==== issuePkg.sv ====
package issuePkg;

    localparam int numLanes = 4;
    localparam int laneDepth = 4;
    localparam int laneIdxW = $clog2(numLanes);
    localparam int entryIdxW = $clog2(laneDepth);

    localparam int numRegs = 8;
    localparam int regIdxW = 3;
    localparam int dataW = 32;

    localparam int numTags = 16;
    localparam int tagW = 4;

    typedef enum logic [2:0] {
        opLi,   // immediate, zero-extended.
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opSll,  // shift by low 5 bits of B.
        opSrl
    } op_t;

    typedef logic [tagW-1:0] tag_t;

    // the ready flag next to the word says which reading holds.
    typedef union packed {
        logic [dataW-1:0] value;
        struct packed {
            logic [dataW-tagW-1:0] pad;
            tag_t tag;
        } pend;
    } operand_t;

endpackage

// ==== laneIf.sv ====
`timescale 1ns/1ns

interface laneIf;

    logic valid;
    issuePkg::op_t op;
    logic [issuePkg::regIdxW-1:0] dst;
    issuePkg::tag_t tag;
    issuePkg::operand_t srcA;
    logic readyA;
    issuePkg::operand_t srcB;
    logic readyB;
    logic full;     // no free entry left.

    modport dispatch (
        output valid, op, dst, tag, srcA, readyA, srcB, readyB,
        input full
    );

    modport lane (
        input valid, op, dst, tag, srcA, readyA, srcB, readyB,
        output full
    );

endinterface

// ==== resultIf.sv ====
`timescale 1ns/1ns

interface resultIf;

    logic valid;
    issuePkg::tag_t tag;
    logic [issuePkg::regIdxW-1:0] dst;
    logic [issuePkg::dataW-1:0] value;
    logic grant;    // result taken at this edge.

    modport lane (output valid, tag, dst, value, input grant);
    modport arbiter (input valid, tag, dst, value, output grant);

    // broadcast side, no handshake.
    modport source (output valid, tag, dst, value);
    modport sink (input valid, tag, dst, value);

endinterface

// ==== renameDispatch.sv ====
`timescale 1ns/1ns

module renameDispatch
(
    input  logic clk,
    input  logic rstN,
    input  logic inValid,
    input  issuePkg::op_t inOp,
    input  logic [issuePkg::regIdxW-1:0] inDst,
    input  logic [issuePkg::regIdxW-1:0] inSrcA,
    input  logic [issuePkg::regIdxW-1:0] inSrcB,
    input  logic [15:0] inImm,
    input  logic [issuePkg::regIdxW-1:0] regAddr,
    output logic inStall,
    output logic busy,
    output logic [issuePkg::dataW-1:0] regData,
    laneIf.dispatch lanes[issuePkg::numLanes],
    resultIf.sink bcast
);

    logic [issuePkg::dataW-1:0] regValue[issuePkg::numRegs];
    logic [issuePkg::numRegs-1:0] regReady;
    issuePkg::tag_t regTag[issuePkg::numRegs];     // newest producer.
    logic [issuePkg::numTags-1:0] tagBusy;
    issuePkg::tag_t nextTag;

    logic [issuePkg::numLanes-1:0] laneHit;
    logic [issuePkg::numLanes-1:0] laneFull;
    logic accept;
    issuePkg::operand_t srcA;
    issuePkg::operand_t srcB;
    logic readyA;
    logic readyB;

    function automatic issuePkg::operand_t readSrc(
        input logic [issuePkg::regIdxW-1:0] idx,
        output logic ready
    );
        issuePkg::operand_t word;
        word = '0;
        ready = 1'b1;
        if (regReady[idx]) begin
            word.value = regValue[idx];
        end else if (bcast.valid && bcast.tag == regTag[idx]) begin
            word.value = bcast.value; // producer finishing this cycle.
        end else begin
            word.pend.tag = regTag[idx];
            ready = 1'b0;
        end
        return word;
    endfunction

    always_comb begin
        srcA = readSrc(inSrcA, readyA);
        srcB = readSrc(inSrcB, readyB);
        if (inOp == issuePkg::opLi) begin
            srcA.value = {{(issuePkg::dataW-16){1'b0}}, inImm};
            readyA = 1'b1;
            srcB.value = '0;
            readyB = 1'b1;
        end
    end

    for (genvar g = 0; g < issuePkg::numLanes; g++) begin : gLane
        assign laneHit[g] = (int'(nextTag) % issuePkg::numLanes) == g;
        assign laneFull[g] = lanes[g].full;

        assign lanes[g].valid = accept && laneHit[g];
        assign lanes[g].op = inOp;
        assign lanes[g].dst = inDst;
        assign lanes[g].tag = nextTag;
        assign lanes[g].srcA = srcA;
        assign lanes[g].readyA = readyA;
        assign lanes[g].srcB = srcB;
        assign lanes[g].readyB = readyB;
    end

    // a tag still in flight cannot be handed out again.
    assign inStall = tagBusy[nextTag] || |(laneHit & laneFull);
    assign accept = inValid && !inStall;
    assign busy = |tagBusy;
    assign regData = regValue[regAddr];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regReady <= '1;
            tagBusy <= '0;
            nextTag <= '0;
            for (int r = 0; r < issuePkg::numRegs; r++) begin
                regValue[r] <= '0;
            end
        end else begin
            if (bcast.valid) begin
                tagBusy[bcast.tag] <= 1'b0;
                for (int r = 0; r < issuePkg::numRegs; r++) begin
                    if (!regReady[r] && regTag[r] == bcast.tag) begin
                        regValue[r] <= bcast.value;
                        regReady[r] <= 1'b1;
                    end
                end
            end
            if (accept) begin
                regReady[inDst] <= 1'b0; // overrides a same-cycle writeback.
                tagBusy[nextTag] <= 1'b1;
                nextTag <= nextTag + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            regTag[inDst] <= nextTag;
        end
    end

endmodule

// ==== issueLane.sv ====
`timescale 1ns/1ns

module issueLane
(
    input logic clk,
    input logic rstN,
    laneIf.lane inst,
    resultIf.lane res,
    resultIf.sink bcast
);

    logic [issuePkg::laneDepth-1:0] entValid;
    logic [issuePkg::laneDepth-1:0] entReadyA;
    logic [issuePkg::laneDepth-1:0] entReadyB;
    issuePkg::op_t entOp[issuePkg::laneDepth];
    logic [issuePkg::regIdxW-1:0] entDst[issuePkg::laneDepth];
    issuePkg::tag_t entTag[issuePkg::laneDepth];
    issuePkg::operand_t entA[issuePkg::laneDepth];
    issuePkg::operand_t entB[issuePkg::laneDepth];
    logic [issuePkg::laneDepth-1:0] older[issuePkg::laneDepth]; // older[j][i]: j before i.

    logic [issuePkg::laneDepth-1:0] rdy;
    logic [issuePkg::entryIdxW-1:0] freeIdx;
    logic [issuePkg::entryIdxW-1:0] issueIdx;
    logic canIssue;
    logic doIssue;
    logic [issuePkg::dataW-1:0] aluOut;

    logic resValid;
    issuePkg::tag_t resTag;
    logic [issuePkg::regIdxW-1:0] resDst;
    logic [issuePkg::dataW-1:0] resValue;

    // oldest entry with both operands present.
    always_comb begin
        logic blocked;
        canIssue = 1'b0;
        issueIdx = '0;
        for (int i = 0; i < issuePkg::laneDepth; i++) begin
            rdy[i] = entValid[i] && entReadyA[i] && entReadyB[i];
        end
        for (int i = 0; i < issuePkg::laneDepth; i++) begin
            blocked = 1'b0;
            for (int j = 0; j < issuePkg::laneDepth; j++) begin
                if (rdy[j] && older[j][i]) blocked = 1'b1;
            end
            if (rdy[i] && !blocked) begin
                canIssue = 1'b1;
                issueIdx = i[issuePkg::entryIdxW-1:0];
            end
        end
    end

    always_comb begin
        freeIdx = '0;
        for (int i = issuePkg::laneDepth - 1; i >= 0; i--) begin
            if (!entValid[i]) freeIdx = i[issuePkg::entryIdxW-1:0];
        end
    end

    assign inst.full = &entValid;
    assign doIssue = canIssue && (!resValid || res.grant); // result slot frees this edge.

    always_comb begin
        logic [issuePkg::dataW-1:0] a;
        logic [issuePkg::dataW-1:0] b;
        a = entA[issueIdx].value;
        b = entB[issueIdx].value;
        case (entOp[issueIdx])
            issuePkg::opLi:  aluOut = a;
            issuePkg::opAdd: aluOut = a + b;
            issuePkg::opSub: aluOut = a - b;
            issuePkg::opAnd: aluOut = a & b;
            issuePkg::opOr:  aluOut = a | b;
            issuePkg::opXor: aluOut = a ^ b;
            issuePkg::opSll: aluOut = a << b[4:0];
            issuePkg::opSrl: aluOut = a >> b[4:0];
            default:         aluOut = a;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            entValid <= '0;
            resValid <= 1'b0;
        end else begin
            if (doIssue) entValid[issueIdx] <= 1'b0;
            if (inst.valid) entValid[freeIdx] <= 1'b1;
            if (doIssue) begin
                resValid <= 1'b1;
            end else if (res.grant) begin
                resValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        // wakeup on the shared broadcast.
        for (int i = 0; i < issuePkg::laneDepth; i++) begin
            if (entValid[i] && bcast.valid) begin
                if (!entReadyA[i] && entA[i].pend.tag == bcast.tag) begin
                    entA[i].value <= bcast.value;
                    entReadyA[i] <= 1'b1;
                end
                if (!entReadyB[i] && entB[i].pend.tag == bcast.tag) begin
                    entB[i].value <= bcast.value;
                    entReadyB[i] <= 1'b1;
                end
            end
        end
        if (inst.valid) begin
            entOp[freeIdx] <= inst.op;
            entDst[freeIdx] <= inst.dst;
            entTag[freeIdx] <= inst.tag;
            entA[freeIdx] <= inst.srcA;
            entReadyA[freeIdx] <= inst.readyA;
            entB[freeIdx] <= inst.srcB;
            entReadyB[freeIdx] <= inst.readyB;
            older[freeIdx] <= '0; // newest, older than nothing.
            for (int j = 0; j < issuePkg::laneDepth; j++) begin
                older[j][freeIdx] <= entValid[j];
            end
        end
        if (doIssue) begin
            resTag <= entTag[issueIdx];
            resDst <= entDst[issueIdx];
            resValue <= aluOut;
        end
    end

    assign res.valid = resValid;
    assign res.tag = resTag;
    assign res.dst = resDst;
    assign res.value = resValue;

endmodule

// ==== wbArbiter.sv ====
`timescale 1ns/1ns

module wbArbiter
(
    input logic clk,
    input logic rstN,
    resultIf.arbiter lanes[issuePkg::numLanes],
    resultIf.source bcast
);

    logic [issuePkg::numLanes-1:0] laneValid;
    issuePkg::tag_t laneTag[issuePkg::numLanes];
    logic [issuePkg::regIdxW-1:0] laneDst[issuePkg::numLanes];
    logic [issuePkg::dataW-1:0] laneValue[issuePkg::numLanes];
    logic [issuePkg::laneIdxW-1:0] ptr;     // first lane to look at.
    logic [issuePkg::laneIdxW-1:0] pick;
    logic found;

    for (genvar g = 0; g < issuePkg::numLanes; g++) begin : gLane
        assign laneValid[g] = lanes[g].valid;
        assign laneTag[g] = lanes[g].tag;
        assign laneDst[g] = lanes[g].dst;
        assign laneValue[g] = lanes[g].value;
        assign lanes[g].grant = found && pick == g;
    end

    always_comb begin
        int idx;
        found = 1'b0;
        pick = ptr;
        for (int k = 0; k < issuePkg::numLanes; k++) begin
            idx = (int'(ptr) + k) % issuePkg::numLanes;
            if (!found && laneValid[idx]) begin
                found = 1'b1;
                pick = idx[issuePkg::laneIdxW-1:0];
            end
        end
    end

    assign bcast.valid = found;
    assign bcast.tag = laneTag[pick];
    assign bcast.dst = laneDst[pick];
    assign bcast.value = laneValue[pick];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ptr <= '0;
        end else if (found) begin
            ptr <= pick + 1'b1; // granted lane goes to the back.
        end
    end

endmodule

// ==== issueCore.sv ====
`timescale 1ns/1ns

module issueCore
(
    input  logic clk,
    input  logic rstN,

    input  logic inValid,
    input  issuePkg::op_t inOp,
    input  logic [issuePkg::regIdxW-1:0] inDst,
    input  logic [issuePkg::regIdxW-1:0] inSrcA,
    input  logic [issuePkg::regIdxW-1:0] inSrcB,
    input  logic [15:0] inImm,
    output logic inStall,

    output logic wbValid,
    output issuePkg::tag_t wbTag,
    output logic [issuePkg::regIdxW-1:0] wbDst,
    output logic [issuePkg::dataW-1:0] wbValue,

    output logic busy,
    input  logic [issuePkg::regIdxW-1:0] regAddr,
    output logic [issuePkg::dataW-1:0] regData
);

    laneIf laneBus[issuePkg::numLanes] ();
    resultIf resBus[issuePkg::numLanes] ();
    resultIf bcast ();

    renameDispatch dispatch0
    (
        .clk(clk),
        .rstN(rstN),
        .inValid(inValid),
        .inOp(inOp),
        .inDst(inDst),
        .inSrcA(inSrcA),
        .inSrcB(inSrcB),
        .inImm(inImm),
        .regAddr(regAddr),
        .inStall(inStall),
        .busy(busy),
        .regData(regData),
        .lanes(laneBus),
        .bcast(bcast)
    );

    for (genvar g = 0; g < issuePkg::numLanes; g++) begin : gLane
        issueLane lane
        (
            .clk(clk),
            .rstN(rstN),
            .inst(laneBus[g]),
            .res(resBus[g]),
            .bcast(bcast)
        );
    end

    wbArbiter arb0
    (
        .clk(clk),
        .rstN(rstN),
        .lanes(resBus),
        .bcast(bcast)
    );

    // results retire straight off the broadcast.
    assign wbValid = bcast.valid;
    assign wbTag = bcast.tag;
    assign wbDst = bcast.dst;
    assign wbValue = bcast.value;

endmodule

// ==== tbIssueCore.sv ====
`timescale 1ns/1ns

module tbIssueCore;

    localparam int numInsts = 400;
    localparam int stallLimit = 200;   // cycles an offered instruction may wait.
    localparam int drainLimit = 2000;

    logic clk;
    logic rstN;
    logic inValid;
    issuePkg::op_t inOp;
    logic [2:0] inDst;
    logic [2:0] inSrcA;
    logic [2:0] inSrcB;
    logic [15:0] inImm;
    logic [2:0] regAddr;
    logic inStall;
    logic wbValid;
    logic [3:0] wbTag;
    logic [2:0] wbDst;
    logic [31:0] wbValue;
    logic busy;
    logic [31:0] regData;

    integer seed;
    logic [31:0] modelReg[8];
    logic [2:0] expDst[16];
    logic [31:0] expValue[16];
    logic [15:0] inFlight;     // tags accepted and not yet written back.
    logic [3:0] modelTag;
    logic sawStall;
    int issued;
    int wbCount;

    issueCore dut0 (
        .clk(clk),
        .rstN(rstN),
        .inValid(inValid),
        .inOp(inOp),
        .inDst(inDst),
        .inSrcA(inSrcA),
        .inSrcB(inSrcB),
        .inImm(inImm),
        .inStall(inStall),
        .wbValid(wbValid),
        .wbTag(wbTag),
        .wbDst(wbDst),
        .wbValue(wbValue),
        .busy(busy),
        .regAddr(regAddr),
        .regData(regData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic abortRun(input string why);
        $display("ERROR: %s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] aluModel(input issuePkg::op_t op, input logic [31:0] a,
                                             input logic [31:0] b, input logic [15:0] imm);
        case (op)
            issuePkg::opLi:  return {16'h0000, imm};
            issuePkg::opAdd: return a + b;
            issuePkg::opSub: return a - b;
            issuePkg::opAnd: return a & b;
            issuePkg::opOr:  return a | b;
            issuePkg::opXor: return a ^ b;
            issuePkg::opSll: return a << b[4:0];
            default:         return a >> b[4:0];
        endcase
    endfunction

    // mostly r0..r3, so that dependencies are frequent.
    function automatic logic [2:0] pickReg();
        logic [31:0] r;
        r = $random(seed);
        if (r[4:3] == 2'b00) return r[2:0];
        return {1'b0, r[1:0]};
    endfunction

    task automatic driveRandom(input int n);
        logic [31:0] r;
        logic chain;
        r = $random(seed);
        chain = (n % 100) >= 60;   // every r5 reads the previous r5.
        if (!chain && r[2:0] == 3'd0) begin
            inValid <= 1'b0;
        end else begin
            inValid <= 1'b1;
            inImm <= r[31:16];
            if (chain) begin
                inOp <= (r[5:3] == 3'd0) ? issuePkg::opAdd : issuePkg::op_t'(r[5:3]);
                inDst <= 3'd5;
                inSrcA <= 3'd5;
                inSrcB <= pickReg();
            end else begin
                inOp <= issuePkg::op_t'(r[5:3]);
                inDst <= pickReg();
                inSrcA <= pickReg();
                inSrcB <= pickReg();
            end
        end
    endtask

    task automatic modelAccept();
        logic [31:0] result;
        result = aluModel(inOp, modelReg[inSrcA], modelReg[inSrcB], inImm);
        check("accepted tag free", 32'd0, {31'd0, inFlight[modelTag]});
        expDst[modelTag] = inDst;
        expValue[modelTag] = result;
        inFlight[modelTag] = 1'b1;
        modelReg[inDst] = result;
        modelTag = modelTag + 4'd1;
    endtask

    always @(negedge clk) begin
        if (rstN && wbValid) begin
            check("writeback tag in flight", 32'd1, {31'd0, inFlight[wbTag]});
            check("writeback dst", {29'd0, expDst[wbTag]}, {29'd0, wbDst});
            check("writeback value", expValue[wbTag], wbValue);
            inFlight[wbTag] = 1'b0;
            wbCount++;
        end
    end

    initial begin
        int waitCycles;
        logic accepted;
        seed = 32'h6049_6918;
        rstN = 1'b0;
        inValid = 1'b0;
        inOp = issuePkg::opLi;
        inDst = '0;
        inSrcA = '0;
        inSrcB = '0;
        inImm = '0;
        regAddr = '0;
        inFlight = '0;
        modelTag = '0;
        sawStall = 1'b0;
        issued = 0;
        wbCount = 0;
        for (int r = 0; r < 8; r++) begin
            modelReg[r] = '0;
        end

        repeat (4) @(posedge clk);
        rstN <= 1'b1;

        @(negedge clk);
        check("busy after reset", 32'd0, {31'd0, busy});
        check("wbValid after reset", 32'd0, {31'd0, wbValid});
        check("inStall after reset", 32'd0, {31'd0, inStall});
        for (int r = 0; r < 8; r++) begin
            @(posedge clk);
            regAddr <= r[2:0];
            @(negedge clk);
            check($sformatf("reset regData r%0d", r), 32'd0, regData);
        end

        @(posedge clk);
        driveRandom(0);
        waitCycles = 0;
        while (issued < numInsts) begin
            @(negedge clk);
            accepted = inValid && !inStall;
            if (inStall) sawStall = 1'b1;
            if (accepted) begin
                modelAccept();
                issued++;
                waitCycles = 0;
            end else if (inValid) begin
                waitCycles++;
                if (waitCycles > stallLimit) abortRun("dispatch stayed stalled too long");
            end
            @(posedge clk);
            if (issued == numInsts) begin
                inValid <= 1'b0;
            end else if (accepted || !inValid) begin
                driveRandom(issued);
            end
        end

        // let every tag in flight drain.
        waitCycles = 0;
        @(negedge clk);
        while (busy) begin
            waitCycles++;
            if (waitCycles > drainLimit) abortRun("busy never fell after the last instruction");
            @(negedge clk);
        end
        check("writebacks per accepted instruction", issued, wbCount);
        check("tags left in flight", 32'd0, {16'd0, inFlight});
        check("inStall seen under dependent chains", 32'd1, {31'd0, sawStall});

        for (int r = 0; r < 8; r++) begin
            @(posedge clk);
            regAddr <= r[2:0];
            @(negedge clk);
            check($sformatf("final regData r%0d", r), modelReg[r], regData);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== files.f ====
issuePkg.sv
laneIf.sv
resultIf.sv
renameDispatch.sv
issueLane.sv
wbArbiter.sv
issueCore.sv
tbIssueCore.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f --top-module tbIssueCore -o simIssueCore

out=$(./obj_dir/simIssueCore 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "^Test completed successfully$"; then
    exit 0
fi
exit 1
